//--- include/soc_mem_map.svh
// SoC memory map
`ifndef SOC_MEM_MAP_SVH
`define SOC_MEM_MAP_SVH

////////////////////////////////////////////////////////////
// Contiguous regions behind the memory port
////////////////////////////////////////////////////////////

// Private bank 0, 32 KB
`define SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR 32'h1C00_0000
`define SOC_MEM_MAP_PRIVATE_BANK0_END_ADDR   32'h1C00_8000

// Private bank 1, 32 KB, directly above bank 0
`define SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR 32'h1C00_8000
`define SOC_MEM_MAP_PRIVATE_BANK1_END_ADDR   32'h1C01_0000

// Boot ROM, 8 KB
`define SOC_MEM_MAP_BOOT_ROM_START_ADDR      32'h1A00_0000
`define SOC_MEM_MAP_BOOT_ROM_END_ADDR        32'h1A00_2000

////////////////////////////////////////////////////////////
// Peripheral region behind the APB master
////////////////////////////////////////////////////////////

`define SOC_MEM_MAP_PERIPHERALS_START_ADDR   32'h1A10_0000
`define SOC_MEM_MAP_PERIPHERALS_END_ADDR     32'h1A40_0000 // End is exclusive

// All end addresses are the first byte past the region

`endif

//--- logic/soc_interconnect_top.sv
// FC data port interconnect
`timescale 1ns/1ps

module soc_interconnect_top import soc_xbar_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    // TCDM slave port
    input  logic      req_i,
    input  logic      wen_i,
    input  addr_t     add_i,
    input  data_t     wdata_i,
    input  be_t       be_i,
    output logic      gnt_o,
    output logic      r_valid_o,
    output data_t     r_rdata_o,
    output logic      r_opc_o,
    // Contiguous memory port
    output logic      mem_req_o,
    output bank_idx_t mem_bank_o,
    output addr_t     mem_add_o,
    output logic      mem_wen_o,
    output data_t     mem_wdata_o,
    output be_t       mem_be_o,
    input  logic      mem_gnt_i,
    input  logic      mem_r_valid_i,
    input  data_t     mem_r_rdata_i,
    // APB master
    output addr_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output data_t     pwdata_o,
    input  logic      pready_i,
    input  data_t     prdata_i,
    input  logic      pslverr_i
);

    logic      push;       // Decoder into queue
    tcdm_req_t dec_req;
    logic      q_valid;    // Queue head to dispatcher
    tcdm_req_t q_req;
    logic      disp_ready;
    tcdm_rsp_t rsp;

    tcdm_addr_decoder i_decoder (
        .clk_i, .reset_i, .req_i, .wen_i, .add_i, .wdata_i, .be_i,
        .gnt_i (gnt_o),
        .push_o(push),
        .req_o (dec_req)
    );

    tcdm_req_queue i_queue (
        .clk_i, .reset_i,
        .push_i (push),
        .req_i  (dec_req),
        .ready_i(disp_ready),
        .gnt_o  (gnt_o),
        .valid_o(q_valid),
        .req_o  (q_req)
    );

    tcdm_target_dispatch i_dispatch (
        .clk_i, .reset_i,
        .valid_i(q_valid), .req_i(q_req), .ready_o(disp_ready),
        .mem_gnt_i, .mem_r_valid_i, .mem_r_rdata_i,
        .mem_req_o, .mem_bank_o, .mem_add_o, .mem_wen_o, .mem_wdata_o, .mem_be_o,
        .pready_i, .pslverr_i, .prdata_i,
        .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o,
        .rsp_valid_o(r_valid_o),
        .rsp_o      (rsp)
    );

    // Response fields out to the master
    assign r_rdata_o = rsp.rdata;
    assign r_opc_o   = rsp.opc;

endmodule

//--- logic/soc_xbar_pkg.sv
// SoC crossbar types and constants
`include "soc_mem_map.svh"

package soc_xbar_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;     // Byte address
    typedef logic [DATA_W-1:0] data_t;     // Data word
    typedef logic [BE_W-1:0]   be_t;       // Byte enables
    typedef logic [1:0]        bank_idx_t; // Index on the contiguous port

    // Legacy alias on the upper address bits
    localparam int PREFIX_LSB = 20;
    localparam int PREFIX_W   = ADDR_W - PREFIX_LSB;
    localparam logic [PREFIX_W-1:0] ALIAS_PREFIX = 12'h000;
    localparam logic [PREFIX_W-1:0] REMAP_PREFIX = 12'h1C0; // 0x000xxxxx maps here

    ////////////////////////////////////////////////////////////
    // Memory map, end addresses exclusive
    ////////////////////////////////////////////////////////////
    localparam addr_t BANK0_START  = `SOC_MEM_MAP_PRIVATE_BANK0_START_ADDR;
    localparam addr_t BANK0_END    = `SOC_MEM_MAP_PRIVATE_BANK0_END_ADDR;
    localparam addr_t BANK1_START  = `SOC_MEM_MAP_PRIVATE_BANK1_START_ADDR;
    localparam addr_t BANK1_END    = `SOC_MEM_MAP_PRIVATE_BANK1_END_ADDR;
    localparam addr_t ROM_START    = `SOC_MEM_MAP_BOOT_ROM_START_ADDR;
    localparam addr_t ROM_END      = `SOC_MEM_MAP_BOOT_ROM_END_ADDR;
    localparam addr_t PERIPH_START = `SOC_MEM_MAP_PERIPHERALS_START_ADDR;
    localparam addr_t PERIPH_END   = `SOC_MEM_MAP_PERIPHERALS_END_ADDR;

    // Target of a request after decode
    typedef enum logic [2:0] {
        REGION_BANK0,
        REGION_BANK1,
        REGION_ROM,
        REGION_PERIPH,
        REGION_NONE   // Unmapped, answered with an error
    } region_e;

    // Decoded request as it travels through the queue
    typedef struct packed {
        addr_t   addr;   // Already remapped
        logic    wen;    // Low for a write
        data_t   wdata;
        be_t     be;
        region_e region;
    } tcdm_req_t;

    // Response back to the master
    typedef struct packed {
        data_t rdata;
        logic  opc;      // High on error
    } tcdm_rsp_t;

    ////////////////////////////////////////////////////////////
    // Request queue
    ////////////////////////////////////////////////////////////
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
    typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;

endpackage

//--- logic/tcdm_addr_decoder.sv
// TCDM address remap and decode
`timescale 1ns/1ps

module tcdm_addr_decoder import soc_xbar_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_i,
    input  logic      wen_i,
    input  addr_t     add_i,
    input  data_t     wdata_i,
    input  be_t       be_i,
    input  logic      gnt_i,    // Free space in the queue
    output logic      push_o,
    output tcdm_req_t req_o
);

    addr_t   add_remap;      // Address after the legacy alias
    region_e region_d;       // Decode handed to the queue

    ////////////////////////////////////////////////////////////
    // Legacy alias 0x000 -> 0x1C0
    ////////////////////////////////////////////////////////////
    always_comb begin
        add_remap = add_i;
        if (add_i[ADDR_W-1:PREFIX_LSB] == ALIAS_PREFIX) begin
            add_remap[ADDR_W-1:PREFIX_LSB] = REMAP_PREFIX;
        end
    end

    // Range compare, first hit wins
    always_comb begin
        region_d = REGION_NONE;                    // Default is the error response
        if (add_remap >= BANK0_START && add_remap < BANK0_END) begin
            region_d = REGION_BANK0;
        end else if (add_remap >= BANK1_START && add_remap < BANK1_END) begin
            region_d = REGION_BANK1;
        end else if (add_remap >= ROM_START && add_remap < ROM_END) begin
            region_d = REGION_ROM;
        end else if (add_remap >= PERIPH_START && add_remap < PERIPH_END) begin
            region_d = REGION_PERIPH;
        end
    end

    assign push_o       = req_i & gnt_i;           // Transfer on req and gnt
    assign req_o.addr   = add_remap;
    assign req_o.wen    = wen_i;
    assign req_o.wdata  = wdata_i;
    assign req_o.be     = be_i;
    assign req_o.region = region_d;

endmodule

//--- logic/tcdm_req_queue.sv
// Decoded request FIFO
`timescale 1ns/1ps

module tcdm_req_queue import soc_xbar_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      push_i,   // Already qualified with the grant
    input  tcdm_req_t req_i,
    input  logic      ready_i,  // Dispatcher is idle
    output logic      gnt_o,
    output logic      valid_o,
    output tcdm_req_t req_o
);

    tcdm_req_t  mem_q [QUEUE_DEPTH]; // Entry storage
    queue_ptr_t wr_ptr_q;
    queue_ptr_t rd_ptr_q;
    queue_cnt_t count_q;             // Entries held
    logic       pop;
    logic       wr_en;

    ////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////
    assign gnt_o   = (count_q != queue_cnt_t'(QUEUE_DEPTH)); // Grant while space left
    assign valid_o = (count_q != '0);
    assign pop     = valid_o & ready_i;
    assign wr_en   = push_i & gnt_o;                         // Guard against overflow

    assign req_o = mem_q[rd_ptr_q]; // Head entry

    // Storage, written at the tail
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at QUEUE_DEPTH
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Both or none
            endcase
        end
    end

endmodule

//--- logic/tcdm_target_dispatch.sv
// Memory and APB request dispatcher
`timescale 1ns/1ps

module tcdm_target_dispatch import soc_xbar_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    // Queue head
    input  logic      valid_i,
    input  tcdm_req_t req_i,
    output logic      ready_o,
    // Contiguous memory port
    input  logic      mem_gnt_i,
    input  logic      mem_r_valid_i,
    input  data_t     mem_r_rdata_i,
    output logic      mem_req_o,
    output bank_idx_t mem_bank_o,
    output addr_t     mem_add_o,
    output logic      mem_wen_o,
    output data_t     mem_wdata_o,
    output be_t       mem_be_o,
    // APB master
    input  logic      pready_i,
    input  logic      pslverr_i,
    input  data_t     prdata_i,
    output addr_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output data_t     pwdata_o,
    // Response
    output logic      rsp_valid_o,
    output tcdm_rsp_t rsp_o
);

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,     // Request held until granted
        MEM_WAIT,    // Waiting for r_valid
        APB_SETUP,
        APB_ACCESS,  // Held until pready
        RESPOND
    } state_e;

    state_e    state_q;
    state_e    state_d;
    logic      pop;
    tcdm_req_t req_q;    // Request in flight
    tcdm_rsp_t rsp_q;    // Captured response

    assign ready_o = (state_q == IDLE);
    assign pop     = valid_i & ready_o;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    case (req_i.region)
                        REGION_BANK0, REGION_BANK1, REGION_ROM: state_d = MEM_REQ;
                        REGION_PERIPH: state_d = APB_SETUP;
                        default:       state_d = RESPOND;   // Unmapped
                    endcase
                end
            end
            MEM_REQ:    if (mem_gnt_i)     state_d = MEM_WAIT;
            MEM_WAIT:   if (mem_r_valid_i) state_d = RESPOND;
            APB_SETUP:  state_d = APB_ACCESS;
            APB_ACCESS: if (pready_i)      state_d = RESPOND;
            RESPOND:    state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latch the popped request
    always_ff @(posedge clk_i) begin
        if (pop) begin
            req_q <= req_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (pop && req_i.region == REGION_NONE) begin
            rsp_q.rdata <= '0;                        // Error, no data
            rsp_q.opc   <= 1'b1;
        end else if (state_q == MEM_WAIT && mem_r_valid_i) begin
            rsp_q.rdata <= req_q.wen ? mem_r_rdata_i : '0; // Writes return 0
            rsp_q.opc   <= 1'b0;
        end else if (state_q == APB_ACCESS && pready_i) begin
            rsp_q.rdata <= req_q.wen ? prdata_i : '0;
            rsp_q.opc   <= pslverr_i;
        end
    end

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_o       = rsp_q;

    // Bank index and offset from the decoded region
    always_comb begin
        case (req_q.region)
            REGION_BANK1: begin
                mem_bank_o = 2'd1;
                mem_add_o  = req_q.addr - BANK1_START;
            end
            REGION_ROM: begin
                mem_bank_o = 2'd2;
                mem_add_o  = req_q.addr - ROM_START;
            end
            default: begin
                mem_bank_o = 2'd0;                    // Bank 0
                mem_add_o  = req_q.addr - BANK0_START;
            end
        endcase
    end

    assign mem_req_o   = (state_q == MEM_REQ);
    assign mem_wen_o   = req_q.wen;
    assign mem_wdata_o = req_q.wdata;
    assign mem_be_o    = req_q.be;

    // APB phases
    assign psel_o    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
    assign penable_o = (state_q == APB_ACCESS);
    assign paddr_o   = req_q.addr;   // Full address on APB
    assign pwrite_o  = ~req_q.wen;
    assign pwdata_o  = req_q.wdata;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the interconnect testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f soc_interconnect_top.f --top-module soc_interconnect_tb \
    -o soc_interconnect_sim &&
./obj_dir/soc_interconnect_sim 2>&1 |
    awk '{ print } /^NO ERRORS$/ { found = 1 } END { exit !found }' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- soc_interconnect_top.f
+incdir+include
logic/soc_xbar_pkg.sv
logic/tcdm_addr_decoder.sv
logic/tcdm_req_queue.sv
logic/tcdm_target_dispatch.sv
logic/soc_interconnect_top.sv
verif/soc_interconnect_assertions.sv
verif/soc_interconnect_tb.sv

//--- verif/soc_interconnect_assertions.sv
// Dispatcher protocol assertions
`timescale 1ns/1ps

module soc_interconnect_assertions import soc_xbar_pkg::*; (
    input logic  clk_i,
    input logic  reset_i,
    input logic  psel_i,
    input logic  penable_i,
    input addr_t paddr_i,
    input logic  mem_req_i,
    input logic  mem_gnt_i
);

    ////////////////////////////////////////////////////////////
    // APB
    ////////////////////////////////////////////////////////////
    penable_psel_a: assert property (@(posedge clk_i) disable iff (reset_i)
        penable_i |-> psel_i)
        else $error("penable high without psel");

    // Address held for the whole transfer
    paddr_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
        psel_i |=> (!psel_i || $stable(paddr_i)))
        else $error("APB address changed during a transfer");

    ////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////
    mem_req_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (mem_req_i && !mem_gnt_i) |=> mem_req_i)
        else $error("Memory request dropped before grant");

    one_target_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(psel_i && mem_req_i))
        else $error("APB and memory port active together");

endmodule

bind tcdm_target_dispatch soc_interconnect_assertions i_assertions (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .psel_i    (psel_o),
    .penable_i (penable_o),
    .paddr_i   (paddr_o),
    .mem_req_i (mem_req_o),
    .mem_gnt_i (mem_gnt_i)
);

//--- verif/soc_interconnect_input.txt
# Columns: test name, write flag, address, write data, byte enables,
#          expected read data, expected error flag (numbers in hex)
b0_wr_full      1 1C000010 11223344 F 00000000 0
b0_wr_be        1 1C000010 AABBCCDD 5 00000000 0
b0_rd           0 1C000010 00000000 F 11BB33DD 0
b1_wr_full      1 1C008020 CAFEF00D F 00000000 0
b1_wr_be        1 1C008020 12345678 C 00000000 0
b1_rd           0 1C008020 00000000 F 1234F00D 0
rom_wr_full     1 1A000100 DEADBEEF F 00000000 0
rom_wr_be       1 1A000100 00000077 1 00000000 0
rom_rd          0 1A000100 00000000 F DEADBE77 0
alias_wr_full   1 1C000040 0BADCAFE F 00000000 0
alias_rd        0 00000040 00000000 F 0BADCAFE 0
alias_wr        1 00008044 55667788 F 00000000 0
alias_rd_full   0 1C008044 00000000 F 55667788 0
apb_wr0         1 1A100008 A5A50001 F 00000000 0
apb_wr1         1 1A20000C 0000BEEF F 00000000 0
apb_rd0         0 1A100008 00000000 F A5A50001 0
apb_rd1         0 1A20000C 00000000 F 0000BEEF 0
apb_err_wr      1 1A300000 12345678 F 00000000 1
apb_err_rd      0 1A3FFFFC 00000000 F 00000000 1
none_rd         0 30000000 00000000 F 00000000 1
none_wr         1 1C010000 87654321 F 00000000 1
none_rom_end    0 1A002000 00000000 F 00000000 1
none_alias      0 00010000 00000000 F 00000000 1
burst_b0        0 1C000010 00000000 F 11BB33DD 0
burst_b1        0 1C008020 00000000 F 1234F00D 0
burst_rom       0 1A000100 00000000 F DEADBE77 0
burst_alias     0 00000040 00000000 F 0BADCAFE 0
burst_b1_hi     0 1C008044 00000000 F 55667788 0
burst_apb       0 1A20000C 00000000 F 0000BEEF 0
burst_b0_again  0 1C000040 00000000 F 0BADCAFE 0

//--- verif/soc_interconnect_tb.sv
// FC data port interconnect testbench
`timescale 1ns/1ps

module soc_interconnect_tb import soc_xbar_pkg::*; ();

    localparam int WATCHDOG_CYCLES_PER_LINE = 200;
    localparam int MEM_WORDS = 8192;                 // 32 KB per bank index

    logic      clk_i;
    logic      reset_i;
    logic      req_i;
    logic      wen_i;
    addr_t     add_i;
    data_t     wdata_i;
    be_t       be_i;
    logic      gnt_o;
    logic      r_valid_o;
    data_t     r_rdata_o;
    logic      r_opc_o;
    logic      mem_req_o;
    bank_idx_t mem_bank_o;
    addr_t     mem_add_o;
    logic      mem_wen_o;
    data_t     mem_wdata_o;
    be_t       mem_be_o;
    logic      mem_gnt_i;
    logic      mem_r_valid_i;
    data_t     mem_r_rdata_i;
    addr_t     paddr_o;
    logic      psel_o;
    logic      penable_o;
    logic      pwrite_o;
    data_t     pwdata_o;
    logic      pready_i;
    data_t     prdata_i;
    logic      pslverr_i;

    // Test table, one entry per stimulus line
    string name_q[$];
    logic  wr_q[$];
    addr_t addr_q[$];
    data_t wdata_q[$];
    be_t   be_q[$];
    data_t exp_rdata_q[$];
    logic  exp_opc_q[$];
    int    pending_q[$];                             // Scoreboard, test indices in request order

    int    line_count    = 0;
    int    granted_count = 0;
    int    rsp_count     = 0;
    logic  loaded        = 1'b0;
    logic  saw_gnt_low   = 1'b0;                     // Queue reached full at least once

    data_t mem [3][MEM_WORDS];                       // Bank 0, bank 1, ROM
    data_t apb_regs [256];

    soc_interconnect_top dut_i (.*);

    always #4 clk_i = ~clk_i;                        // 8 ns period

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            report_failure($sformatf("FAILED %s expected %08h actual %08h",
                                     name, expected, actual));
        end
    endtask

    // Byte lane merge of a write into a stored word
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // Bank index and region offset a memory access must carry
    task automatic check_mem_target(input int idx);
        addr_t     addr;
        bank_idx_t bank;
        addr_t     base;
        addr = addr_q[idx];
        if (addr[31:20] == 12'h000) begin
            addr[31:20] = 12'h1C0;                   // Legacy alias
        end
        if (addr >= BANK0_START && addr < BANK0_END) begin
            bank = 2'd0;
            base = BANK0_START;
        end else if (addr >= BANK1_START && addr < BANK1_END) begin
            bank = 2'd1;
            base = BANK1_START;
        end else if (addr >= ROM_START && addr < ROM_END) begin
            bank = 2'd2;
            base = ROM_START;
        end else begin
            report_failure({name_q[idx], " reached the memory port outside the memory map"});
        end
        check_value({name_q[idx], " mem_bank"}, data_t'(bank), data_t'(mem_bank_o));
        check_value({name_q[idx], " mem_add"}, addr - base, mem_add_o);
    endtask

    task automatic load_stimulus();
        int    fd;
        int    fields;
        string line;
        string name;
        data_t col [6];                              // wr, addr, wdata, be, rdata, opc
        fd = $fopen("verif/soc_interconnect_input.txt", "r");
        if (fd == 0) report_failure("Could not open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                line_count++;
                if (line.len() > 1 && line.getc(0) != "#") begin   // Skip blanks and comments
                    fields = $sscanf(line, "%s %h %h %h %h %h %h", name,
                                     col[0], col[1], col[2], col[3], col[4], col[5]);
                    if (fields != 7) report_failure({"Malformed stimulus line: ", line});
                    name_q.push_back(name);
                    wr_q.push_back(col[0][0]);
                    addr_q.push_back(col[1]);
                    wdata_q.push_back(col[2]);
                    be_q.push_back(be_t'(col[3]));
                    exp_rdata_q.push_back(col[4]);
                    exp_opc_q.push_back(col[5][0]);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin : main_sequence
        void'($urandom(32'h39da_5a47));
        clk_i   = 1'b0;
        reset_i = 1'b1;
        req_i   = 1'b0;
        wen_i   = 1'b1;                              // Read when idle
        add_i   = '0;
        wdata_i = '0;
        be_i    = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (3) @(negedge clk_i);                 // Reset seen on 3 rising edges
        reset_i = 1'b0;
        check_value("reset_gnt", 1, gnt_o);          // Empty queue grants
        check_value("reset_r_valid", 0, r_valid_o);
        check_value("reset_mem_req", 0, mem_req_o);
        check_value("reset_psel", 0, psel_o);
        check_value("reset_penable", 0, penable_o);
        for (int i = 0; i < name_q.size(); i++) begin
            req_i   = 1'b1;
            wen_i   = ~wr_q[i];                      // TCDM wen is active low
            add_i   = addr_q[i];
            wdata_i = wdata_q[i];
            be_i    = be_q[i];
            while (!gnt_o) @(negedge clk_i);         // Hold until granted
            pending_q.push_back(i);
            granted_count++;
            @(negedge clk_i);                        // Transfer on the rising edge in between
        end
        req_i = 1'b0;
        wait (rsp_count == name_q.size());
        check_value("gnt_backpressure", 1, saw_gnt_low);
        $display("NO ERRORS");
        $finish;
    end

    // Responses and grant, sampled mid-cycle
    always @(negedge clk_i) begin : response_monitor
        int idx;
        if (!reset_i) begin
            if (!gnt_o) begin
                saw_gnt_low = 1'b1;
                if (granted_count - rsp_count < QUEUE_DEPTH)
                    report_failure("Grant fell with fewer than four requests pending");
            end
            if (granted_count - rsp_count > QUEUE_DEPTH + 1) begin
                report_failure("More than five requests in flight");
            end
            if (r_valid_o) begin
                if (pending_q.size() == 0) begin
                    report_failure("Response arrived with no request pending");
                end else begin
                    idx = pending_q.pop_front();
                    check_value({name_q[idx], " rdata"}, exp_rdata_q[idx], r_rdata_o);
                    check_value({name_q[idx], " opc"}, data_t'(exp_opc_q[idx]),
                                data_t'(r_opc_o));
                    rsp_count++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Slave models
    ////////////////////////////////////////////////////////////
    initial begin : memory_model
        int unsigned delay;
        bank_idx_t   bank;
        logic [12:0] word;
        data_t       rdata;
        for (int b = 0; b < 3; b++) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[b][w] = {6'h2B, b[1:0], 11'h000, w[12:0]};  // Fill from bank and word
            end
        end
        mem_gnt_i     = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_rdata_i = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                if (pending_q.size() == 0) begin
                    report_failure("Memory request with no request pending");
                end else begin
                    check_mem_target(pending_q[0]);  // Oldest pending is in the dispatcher
                end
                delay = $urandom_range(3, 0);        // Grant delay
                repeat (delay) @(negedge clk_i);
                mem_gnt_i = 1'b1;
                bank      = mem_bank_o;
                word      = mem_add_o[14:2];
                if (!mem_wen_o) begin
                    mem[bank][word] = merge_bytes(mem[bank][word], mem_wdata_o, mem_be_o);
                end
                rdata = mem[bank][word];
                @(negedge clk_i);
                mem_gnt_i = 1'b0;
                delay     = $urandom_range(3, 0);    // Read data delay
                repeat (delay) @(negedge clk_i);
                mem_r_valid_i = 1'b1;
                mem_r_rdata_i = rdata;
                @(negedge clk_i);
                mem_r_valid_i = 1'b0;
            end
        end
    end

    initial begin : apb_model
        int unsigned delay;
        logic        slverr;
        for (int r = 0; r < 256; r++) begin
            apb_regs[r] = 32'h5A00_0000 | (r << 8) | r;
        end
        pready_i  = 1'b0;
        prdata_i  = '0;
        pslverr_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (psel_o && penable_o) begin
                delay = $urandom_range(3, 0);        // Wait states
                repeat (delay) @(negedge clk_i);
                slverr    = (paddr_o >= 32'h1A30_0000);
                pready_i  = 1'b1;
                pslverr_i = slverr;
                prdata_i  = slverr ? '0 : apb_regs[paddr_o[9:2]];
                if (pwrite_o && !slverr) apb_regs[paddr_o[9:2]] = pwdata_o;
                @(negedge clk_i);
                pready_i  = 1'b0;
                pslverr_i = 1'b0;
                prdata_i  = '0;
            end
        end
    end

    // Run limit scales with the stimulus length
    initial begin : watchdog
        wait (loaded);
        repeat (WATCHDOG_CYCLES_PER_LINE * line_count) @(posedge clk_i);
        report_failure("Timeout, the run did not finish in the allowed number of cycles");
    end

endmodule
